// File: flist.f
gs_pkg.sv
gs_regfile.sv
gs_if_stage.sv
gs_id_stage.sv
gs_ex_stage.sv
gs_ctrl_unit.sv
gs_core.sv
gs_core_assert.sv
tb_gs_core.sv

// File: gs_core.sv
`timescale 1ns/100ps
module gs_core (
    input  logic                    clk_i,
    input  logic                    rst_n_i,
    output logic [gs_pkg::XLEN-1:0] im_addr_o,
    input  logic [gs_pkg::XLEN-1:0] im_data_i,
    output logic [gs_pkg::XLEN-1:0] dm_addr_o,
    output logic [gs_pkg::XLEN-1:0] dm_wdata_o,
    output logic                    dm_we_o,
    input  logic [gs_pkg::XLEN-1:0] dm_rdata_i
);

    // fetch/decode register
    logic [gs_pkg::XLEN-1:0]       if_instr, if_pc;
    logic                          if_valid;
    // decode outputs
    logic [gs_pkg::REG_ADDR_W-1:0] rs1_addr, rs2_addr, id_rd;
    logic                          rs1_used, rs2_used, jal, id_valid;
    logic [gs_pkg::XLEN-1:0]       jal_target, id_op_a, id_op_b, id_store_data;
    logic [gs_pkg::XLEN-1:0]       id_pc, id_imm;
    gs_pkg::alu_op_e               id_alu_op;
    logic                          id_reg_write, id_load, id_store;
    logic                          id_branch, id_bne, id_jalr;
    // execute and writeback feedback
    logic [gs_pkg::XLEN-1:0]       ex_result, redirect_target, wb_data;
    logic [gs_pkg::REG_ADDR_W-1:0] ex_rd, wb_rd;
    logic                          ex_reg_write, ex_load, redirect, wb_we;
    // control
    gs_pkg::pc_sel_e               pc_sel;
    gs_pkg::fwd_sel_e              fwd_rs1, fwd_rs2;
    logic                          stall, flush_id, flush_ex;

    gs_if_stage u_if_stage (
        .clk_i (clk_i), .rst_n_i (rst_n_i), .pc_sel_i (pc_sel),
        .stall_i (stall), .flush_i (flush_id),
        .jal_target_i (jal_target), .redirect_target_i (redirect_target),
        .im_addr_o (im_addr_o), .im_data_i (im_data_i),
        .instr_o (if_instr), .pc_o (if_pc), .valid_o (if_valid)
    );

    gs_id_stage u_id_stage (
        .clk_i (clk_i), .rst_n_i (rst_n_i),
        .instr_i (if_instr), .pc_i (if_pc), .valid_i (if_valid),
        .stall_i (stall), .flush_i (flush_ex),
        .fwd_rs1_i (fwd_rs1), .fwd_rs2_i (fwd_rs2), .ex_result_i (ex_result),
        .wb_we_i (wb_we), .wb_rd_i (wb_rd), .wb_data_i (wb_data),
        .rs1_addr_o (rs1_addr), .rs2_addr_o (rs2_addr),
        .rs1_used_o (rs1_used), .rs2_used_o (rs2_used),
        .jal_o (jal), .jal_target_o (jal_target),
        .ex_valid_o (id_valid), .ex_alu_op_o (id_alu_op),
        .ex_op_a_o (id_op_a), .ex_op_b_o (id_op_b), .ex_store_data_o (id_store_data),
        .ex_rd_o (id_rd), .ex_reg_write_o (id_reg_write), .ex_load_o (id_load),
        .ex_store_o (id_store), .ex_branch_o (id_branch), .ex_bne_o (id_bne),
        .ex_jalr_o (id_jalr), .ex_pc_o (id_pc), .ex_imm_o (id_imm)
    );

    gs_ex_stage u_ex_stage (
        .clk_i (clk_i), .rst_n_i (rst_n_i),
        .ex_valid_i (id_valid), .ex_alu_op_i (id_alu_op),
        .ex_op_a_i (id_op_a), .ex_op_b_i (id_op_b), .ex_store_data_i (id_store_data),
        .ex_rd_i (id_rd), .ex_reg_write_i (id_reg_write), .ex_load_i (id_load),
        .ex_store_i (id_store), .ex_branch_i (id_branch), .ex_bne_i (id_bne),
        .ex_jalr_i (id_jalr), .ex_pc_i (id_pc), .ex_imm_i (id_imm),
        .dm_rdata_i (dm_rdata_i), .ex_result_o (ex_result), .ex_rd_o (ex_rd),
        .ex_reg_write_o (ex_reg_write), .ex_load_o (ex_load),
        .redirect_o (redirect), .redirect_target_o (redirect_target),
        .dm_addr_o (dm_addr_o), .dm_wdata_o (dm_wdata_o), .dm_we_o (dm_we_o),
        .wb_we_o (wb_we), .wb_rd_o (wb_rd), .wb_data_o (wb_data)
    );

    gs_ctrl_unit u_ctrl_unit (
        .rs1_addr_i (rs1_addr), .rs2_addr_i (rs2_addr),
        .rs1_used_i (rs1_used), .rs2_used_i (rs2_used),
        .ex_rd_i (ex_rd), .ex_reg_write_i (ex_reg_write), .ex_load_i (ex_load),
        .wb_we_i (wb_we), .wb_rd_i (wb_rd), .jal_i (jal), .redirect_i (redirect),
        .fwd_rs1_o (fwd_rs1), .fwd_rs2_o (fwd_rs2), .stall_o (stall),
        .flush_id_o (flush_id), .flush_ex_o (flush_ex), .pc_sel_o (pc_sel)
    );

endmodule

// File: gs_core_assert.sv
`timescale 1ns/100ps
module gs_core_assert (
    input logic                    clk_i,
    input logic                    rst_n_i,
    input logic [gs_pkg::XLEN-1:0] im_addr_i,
    input logic                    dm_we_i
);

    // pc parked at the boot address while reset is held
    a_reset_state: assert property (
        @(posedge clk_i) !rst_n_i |-> im_addr_i == gs_pkg::BOOT_ADDR && !dm_we_i
    ) else $error("fetch address or store strobe wrong while in reset");

    // first clock after release still fetches from boot
    a_reset_exit: assert property (
        @(posedge clk_i) $rose(rst_n_i) |-> im_addr_i == gs_pkg::BOOT_ADDR && !dm_we_i
    ) else $error("fetch address or store strobe wrong right after reset");

    // only word fetches exist in this core
    a_fetch_aligned: assert property (
        @(posedge clk_i) im_addr_i[1:0] == 2'b00
    ) else $error("fetch address not word aligned");

    // a store strobe must never start while reset is held
    a_no_store_in_reset: assert property (
        @(posedge dm_we_i) rst_n_i
    ) else $error("store strobe rose while reset was held");

endmodule

bind gs_core gs_core_assert u_core_assert (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .im_addr_i (im_addr_o),
    .dm_we_i   (dm_we_o)
);

// File: gs_ctrl_unit.sv
`timescale 1ns/100ps
module gs_ctrl_unit (
    input  logic [gs_pkg::REG_ADDR_W-1:0] rs1_addr_i,
    input  logic [gs_pkg::REG_ADDR_W-1:0] rs2_addr_i,
    input  logic                          rs1_used_i,
    input  logic                          rs2_used_i,
    input  logic [gs_pkg::REG_ADDR_W-1:0] ex_rd_i,
    input  logic                          ex_reg_write_i,
    input  logic                          ex_load_i,
    input  logic                          wb_we_i,
    input  logic [gs_pkg::REG_ADDR_W-1:0] wb_rd_i,
    input  logic                          jal_i,
    input  logic                          redirect_i,
    output gs_pkg::fwd_sel_e              fwd_rs1_o,
    output gs_pkg::fwd_sel_e              fwd_rs2_o,
    output logic                          stall_o,
    output logic                          flush_id_o,
    output logic                          flush_ex_o,
    output gs_pkg::pc_sel_e               pc_sel_o
);

    logic rs1_ex_hit, rs2_ex_hit, rs1_wb_hit, rs2_wb_hit;

    // x0 never matches
    assign rs1_ex_hit = ex_reg_write_i && (ex_rd_i == rs1_addr_i) && (rs1_addr_i != '0);
    assign rs2_ex_hit = ex_reg_write_i && (ex_rd_i == rs2_addr_i) && (rs2_addr_i != '0);
    assign rs1_wb_hit = wb_we_i && (wb_rd_i == rs1_addr_i) && (rs1_addr_i != '0);
    assign rs2_wb_hit = wb_we_i && (wb_rd_i == rs2_addr_i) && (rs2_addr_i != '0);

    // younger producer first
    assign fwd_rs1_o = rs1_ex_hit ? gs_pkg::FWD_EX :
                       rs1_wb_hit ? gs_pkg::FWD_WB : gs_pkg::FWD_RF;
    assign fwd_rs2_o = rs2_ex_hit ? gs_pkg::FWD_EX :
                       rs2_wb_hit ? gs_pkg::FWD_WB : gs_pkg::FWD_RF;

    // load data not ready until writeback, hold one cycle
    assign stall_o = ex_load_i && !redirect_i &&
                     ((rs1_used_i && rs1_ex_hit) || (rs2_used_i && rs2_ex_hit));

    // redirect kills both younger slots, jal only the fetched one
    assign flush_id_o = redirect_i | jal_i;
    assign flush_ex_o = redirect_i;

    assign pc_sel_o = redirect_i ? gs_pkg::PC_REDIRECT :
                      jal_i      ? gs_pkg::PC_JAL      : gs_pkg::PC_SEQ;

endmodule

// File: gs_ex_stage.sv
`timescale 1ns/100ps
module gs_ex_stage (
    input  logic                          clk_i,
    input  logic                          rst_n_i,
    input  logic                          ex_valid_i,
    input  gs_pkg::alu_op_e               ex_alu_op_i,
    input  logic [gs_pkg::XLEN-1:0]       ex_op_a_i,
    input  logic [gs_pkg::XLEN-1:0]       ex_op_b_i,
    input  logic [gs_pkg::XLEN-1:0]       ex_store_data_i,
    input  logic [gs_pkg::REG_ADDR_W-1:0] ex_rd_i,
    input  logic                          ex_reg_write_i,
    input  logic                          ex_load_i,
    input  logic                          ex_store_i,
    input  logic                          ex_branch_i,
    input  logic                          ex_bne_i,
    input  logic                          ex_jalr_i,
    input  logic [gs_pkg::XLEN-1:0]       ex_pc_i,
    input  logic [gs_pkg::XLEN-1:0]       ex_imm_i,
    input  logic [gs_pkg::XLEN-1:0]       dm_rdata_i,
    output logic [gs_pkg::XLEN-1:0]       ex_result_o,
    output logic [gs_pkg::REG_ADDR_W-1:0] ex_rd_o,
    output logic                          ex_reg_write_o,
    output logic                          ex_load_o,
    output logic                          redirect_o,
    output logic [gs_pkg::XLEN-1:0]       redirect_target_o,
    output logic [gs_pkg::XLEN-1:0]       dm_addr_o,
    output logic [gs_pkg::XLEN-1:0]       dm_wdata_o,
    output logic                          dm_we_o,
    output logic                          wb_we_o,
    output logic [gs_pkg::REG_ADDR_W-1:0] wb_rd_o,
    output logic [gs_pkg::XLEN-1:0]       wb_data_o
);

    logic [gs_pkg::XLEN-1:0]       alu_res;
    logic [gs_pkg::XLEN-1:0]       jalr_sum;
    logic                          taken;
    logic [gs_pkg::XLEN-1:0]       res_q, sdata_q;
    logic [gs_pkg::REG_ADDR_W-1:0] rd_q;
    logic                          reg_write_q, load_q, store_q;

    always_comb begin
        case (ex_alu_op_i)
            gs_pkg::ALU_SUB: alu_res = ex_op_a_i - ex_op_b_i;
            gs_pkg::ALU_AND: alu_res = ex_op_a_i & ex_op_b_i;
            gs_pkg::ALU_OR:  alu_res = ex_op_a_i | ex_op_b_i;
            gs_pkg::ALU_XOR: alu_res = ex_op_a_i ^ ex_op_b_i;
            gs_pkg::ALU_SLT: begin
                alu_res = {{(gs_pkg::XLEN-1){1'b0}},
                           $signed(ex_op_a_i) < $signed(ex_op_b_i)};
            end
            default:         alu_res = ex_op_a_i + ex_op_b_i;
        endcase
    end

    // beq on equal, bne on not equal
    assign taken      = ex_branch_i & ((ex_op_a_i == ex_op_b_i) ^ ex_bne_i);
    assign redirect_o = ex_valid_i & (taken | ex_jalr_i);

    // jalr base arrives on the store data lane
    assign jalr_sum          = ex_store_data_i + ex_imm_i;
    assign redirect_target_o = ex_jalr_i ? {jalr_sum[gs_pkg::XLEN-1:1], 1'b0}
                                         : ex_pc_i + ex_imm_i;

    // for forwarding and load-to-use detection
    assign ex_result_o    = alu_res;
    assign ex_rd_o        = ex_rd_i;
    assign ex_reg_write_o = ex_valid_i & ex_reg_write_i;
    assign ex_load_o      = ex_valid_i & ex_load_i;

    // execute/writeback control
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            reg_write_q <= 1'b0;
            load_q      <= 1'b0;
            store_q     <= 1'b0;
        end else begin
            reg_write_q <= ex_reg_write_o;
            load_q      <= ex_load_o;
            store_q     <= ex_valid_i & ex_store_i;
        end
    end

    always_ff @(posedge clk_i) begin
        res_q   <= alu_res;
        sdata_q <= ex_store_data_i;
        rd_q    <= ex_rd_i;
    end

    // data memory straight from the register, one-cycle write strobe
    assign dm_addr_o  = res_q;
    assign dm_wdata_o = sdata_q;
    assign dm_we_o    = store_q;

    // load data comes back combinationally
    assign wb_we_o   = reg_write_q;
    assign wb_rd_o   = rd_q;
    assign wb_data_o = load_q ? dm_rdata_i : res_q;

endmodule

// File: gs_id_stage.sv
`timescale 1ns/100ps
module gs_id_stage (
    input  logic                          clk_i,
    input  logic                          rst_n_i,
    input  logic [gs_pkg::XLEN-1:0]       instr_i,
    input  logic [gs_pkg::XLEN-1:0]       pc_i,
    input  logic                          valid_i,
    input  logic                          stall_i,
    input  logic                          flush_i,
    input  gs_pkg::fwd_sel_e              fwd_rs1_i,
    input  gs_pkg::fwd_sel_e              fwd_rs2_i,
    input  logic [gs_pkg::XLEN-1:0]       ex_result_i,
    input  logic                          wb_we_i,
    input  logic [gs_pkg::REG_ADDR_W-1:0] wb_rd_i,
    input  logic [gs_pkg::XLEN-1:0]       wb_data_i,
    output logic [gs_pkg::REG_ADDR_W-1:0] rs1_addr_o,
    output logic [gs_pkg::REG_ADDR_W-1:0] rs2_addr_o,
    output logic                          rs1_used_o,
    output logic                          rs2_used_o,
    output logic                          jal_o,
    output logic [gs_pkg::XLEN-1:0]       jal_target_o,
    output logic                          ex_valid_o,
    output gs_pkg::alu_op_e               ex_alu_op_o,
    output logic [gs_pkg::XLEN-1:0]       ex_op_a_o,
    output logic [gs_pkg::XLEN-1:0]       ex_op_b_o,
    output logic [gs_pkg::XLEN-1:0]       ex_store_data_o,
    output logic [gs_pkg::REG_ADDR_W-1:0] ex_rd_o,
    output logic                          ex_reg_write_o,
    output logic                          ex_load_o,
    output logic                          ex_store_o,
    output logic                          ex_branch_o,
    output logic                          ex_bne_o,
    output logic                          ex_jalr_o,
    output logic [gs_pkg::XLEN-1:0]       ex_pc_o,
    output logic [gs_pkg::XLEN-1:0]       ex_imm_o
);

    logic [6:0]              opcode;
    logic [2:0]              funct3;
    logic [gs_pkg::XLEN-1:0] imm_i, imm_s, imm_b, imm_j, imm;
    logic [gs_pkg::XLEN-1:0] rs1_rf, rs2_rf, rs1_val, rs2_val;
    gs_pkg::alu_op_e         alu_op;
    logic                    reg_write, load, store, branch, jalr, jal;
    logic                    link, b_imm, rs1_used, rs2_used;

    // operand source, execute result or writeback data
    function automatic logic [gs_pkg::XLEN-1:0] fwd_pick(
        input gs_pkg::fwd_sel_e        sel,
        input logic [gs_pkg::XLEN-1:0] rf_val,
        input logic [gs_pkg::XLEN-1:0] ex_val,
        input logic [gs_pkg::XLEN-1:0] wb_val
    );
        case (sel)
            gs_pkg::FWD_EX: fwd_pick = ex_val;
            gs_pkg::FWD_WB: fwd_pick = wb_val;
            default:        fwd_pick = rf_val;
        endcase
    endfunction

    gs_regfile u_regfile (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .rs1_addr_i (rs1_addr_o),
        .rs2_addr_i (rs2_addr_o),
        .rs1_data_o (rs1_rf),
        .rs2_data_o (rs2_rf),
        .we_i       (wb_we_i),
        .rd_addr_i  (wb_rd_i),
        .rd_data_i  (wb_data_i)
    );

    assign opcode     = instr_i[6:0];
    assign funct3     = instr_i[14:12];
    assign rs1_addr_o = instr_i[19:15];
    assign rs2_addr_o = instr_i[24:20];

    // sign-extended immediates, b and j have bit 0 clear
    assign imm_i = {{20{instr_i[31]}}, instr_i[31:20]};
    assign imm_s = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
    assign imm_b = {{19{instr_i[31]}}, instr_i[31], instr_i[7], instr_i[30:25],
                    instr_i[11:8], 1'b0};
    assign imm_j = {{11{instr_i[31]}}, instr_i[31], instr_i[19:12], instr_i[20],
                    instr_i[30:21], 1'b0};

    always_comb begin
        alu_op    = gs_pkg::ALU_ADD;
        imm       = imm_i;
        reg_write = 1'b0;
        load      = 1'b0;
        store     = 1'b0;
        branch    = 1'b0;
        jalr      = 1'b0;
        jal       = 1'b0;
        link      = 1'b0;
        b_imm     = 1'b0;
        rs1_used  = 1'b0;
        rs2_used  = 1'b0;
        case (opcode)
            gs_pkg::OPC_OP: begin
                reg_write = 1'b1;
                rs1_used  = 1'b1;
                rs2_used  = 1'b1;
            end
            gs_pkg::OPC_OP_IMM: begin
                reg_write = 1'b1;
                rs1_used  = 1'b1;
                b_imm     = 1'b1;
            end
            gs_pkg::OPC_LOAD: begin
                reg_write = 1'b1;
                load      = 1'b1;
                rs1_used  = 1'b1;
                b_imm     = 1'b1;
            end
            gs_pkg::OPC_STORE: begin
                store    = 1'b1;
                rs1_used = 1'b1;
                rs2_used = 1'b1;
                b_imm    = 1'b1;
                imm      = imm_s;
            end
            gs_pkg::OPC_BRANCH: begin
                // only beq and bne exist here
                branch   = (funct3 == gs_pkg::F3_BEQ) || (funct3 == gs_pkg::F3_BNE);
                rs1_used = 1'b1;
                rs2_used = 1'b1;
                imm      = imm_b;
                alu_op   = gs_pkg::ALU_SUB;
            end
            gs_pkg::OPC_JAL: begin
                jal       = 1'b1;
                reg_write = 1'b1;
                link      = 1'b1;
            end
            gs_pkg::OPC_JALR: begin
                jalr      = 1'b1;
                reg_write = 1'b1;
                link      = 1'b1;
                rs1_used  = 1'b1;
            end
            default: begin
            end
        endcase
        // alu function of register and immediate ops
        if (opcode == gs_pkg::OPC_OP || opcode == gs_pkg::OPC_OP_IMM) begin
            case (funct3)
                gs_pkg::F3_ADD: begin
                    alu_op = (opcode == gs_pkg::OPC_OP && instr_i[30]) ?
                             gs_pkg::ALU_SUB : gs_pkg::ALU_ADD;
                end
                gs_pkg::F3_XOR: alu_op = gs_pkg::ALU_XOR;
                gs_pkg::F3_OR:  alu_op = gs_pkg::ALU_OR;
                gs_pkg::F3_AND: alu_op = gs_pkg::ALU_AND;
                gs_pkg::F3_SLT: alu_op = gs_pkg::ALU_SLT;
                // shifts and others dropped, no writeback
                default:        reg_write = 1'b0;
            endcase
        end
    end

    assign rs1_val = fwd_pick(fwd_rs1_i, rs1_rf, ex_result_i, wb_data_i);
    assign rs2_val = fwd_pick(fwd_rs2_i, rs2_rf, ex_result_i, wb_data_i);

    // flushed slot must not stall or jump
    assign rs1_used_o   = valid_i & rs1_used;
    assign rs2_used_o   = valid_i & rs2_used;
    assign jal_o        = valid_i & jal;
    assign jal_target_o = pc_i + imm_j;

    // control half, stall or flush leaves a bubble
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ex_valid_o     <= 1'b0;
            ex_reg_write_o <= 1'b0;
            ex_load_o      <= 1'b0;
            ex_store_o     <= 1'b0;
            ex_branch_o    <= 1'b0;
            ex_bne_o       <= 1'b0;
            ex_jalr_o      <= 1'b0;
        end else begin
            ex_valid_o     <= valid_i & ~stall_i & ~flush_i;
            ex_reg_write_o <= reg_write;
            ex_load_o      <= load;
            ex_store_o     <= store;
            ex_branch_o    <= branch;
            ex_bne_o       <= (funct3 == gs_pkg::F3_BNE);
            ex_jalr_o      <= jalr;
        end
    end

    // payload half
    always_ff @(posedge clk_i) begin
        ex_alu_op_o <= alu_op;
        // link value pc+4 goes through the alu as pc+4 plus zero
        ex_op_a_o   <= link ? pc_i + 32'd4 : rs1_val;
        ex_op_b_o   <= link ? '0 : (b_imm ? imm : rs2_val);
        // rs2 for stores, jalr carries its base register here
        ex_store_data_o <= jalr ? rs1_val : rs2_val;
        ex_rd_o     <= instr_i[11:7];
        ex_pc_o     <= pc_i;
        ex_imm_o    <= imm;
    end

endmodule

// File: gs_if_stage.sv
`timescale 1ns/100ps
module gs_if_stage (
    input  logic                    clk_i,
    input  logic                    rst_n_i,
    input  gs_pkg::pc_sel_e         pc_sel_i,
    input  logic                    stall_i,
    input  logic                    flush_i,
    input  logic [gs_pkg::XLEN-1:0] jal_target_i,
    input  logic [gs_pkg::XLEN-1:0] redirect_target_i,
    output logic [gs_pkg::XLEN-1:0] im_addr_o,
    input  logic [gs_pkg::XLEN-1:0] im_data_i,
    output logic [gs_pkg::XLEN-1:0] instr_o,
    output logic [gs_pkg::XLEN-1:0] pc_o,
    output logic                    valid_o
);

    logic [gs_pkg::XLEN-1:0] pc_q;
    logic [gs_pkg::XLEN-1:0] pc_next;

    // redirect beats the stall, the stall beats jal
    always_comb begin
        pc_next = pc_q + 32'd4;
        if (pc_sel_i == gs_pkg::PC_REDIRECT) begin
            pc_next = redirect_target_i;
        end else if (stall_i) begin
            pc_next = pc_q;
        end else if (pc_sel_i == gs_pkg::PC_JAL) begin
            pc_next = jal_target_i;
        end
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            pc_q <= gs_pkg::BOOT_ADDR;
        end else begin
            pc_q <= pc_next;
        end
    end

    // fetch/decode valid, flush wins over hold
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            valid_o <= 1'b0;
        end else if (flush_i) begin
            valid_o <= 1'b0;
        end else if (!stall_i) begin
            valid_o <= 1'b1;
        end
    end

    // instruction word and its pc
    always_ff @(posedge clk_i) begin
        if (!stall_i) begin
            instr_o <= im_data_i;
            pc_o    <= pc_q;
        end
    end

    // memory returns the word in the same cycle
    assign im_addr_o = pc_q;

endmodule

// File: gs_pkg.sv
package gs_pkg;

    // datapath and address width
    localparam int unsigned XLEN = 32;
    // register index width, 32 architectural registers
    localparam int unsigned REG_ADDR_W = 5;

    // first fetch address after reset
    localparam logic [XLEN-1:0] BOOT_ADDR = 32'h0000_0000;

    // major opcodes of the supported subset
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;

    // funct3 for alu ops
    localparam logic [2:0] F3_ADD = 3'b000;
    localparam logic [2:0] F3_XOR = 3'b100;
    localparam logic [2:0] F3_OR  = 3'b110;
    localparam logic [2:0] F3_AND = 3'b111;
    localparam logic [2:0] F3_SLT = 3'b010;

    // funct3 for branches
    localparam logic [2:0] F3_BEQ = 3'b000;
    localparam logic [2:0] F3_BNE = 3'b001;

    // alu function, slt is signed
    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT
    } alu_op_e;

    // operand source in decode
    typedef enum logic [1:0] {
        FWD_RF,
        FWD_EX,
        FWD_WB
    } fwd_sel_e;

    // next pc source, a stall holds the pc on top of this
    typedef enum logic [1:0] {
        PC_SEQ,
        PC_JAL,
        PC_REDIRECT
    } pc_sel_e;

endpackage

// File: gs_regfile.sv
`timescale 1ns/100ps
module gs_regfile (
    input  logic                          clk_i,
    input  logic                          rst_n_i,
    input  logic [gs_pkg::REG_ADDR_W-1:0] rs1_addr_i,
    input  logic [gs_pkg::REG_ADDR_W-1:0] rs2_addr_i,
    output logic [gs_pkg::XLEN-1:0]       rs1_data_o,
    output logic [gs_pkg::XLEN-1:0]       rs2_data_o,
    input  logic                          we_i,
    input  logic [gs_pkg::REG_ADDR_W-1:0] rd_addr_i,
    input  logic [gs_pkg::XLEN-1:0]       rd_data_i
);

    // x1..x31 only, x0 has no storage
    logic [gs_pkg::XLEN-1:0] regs_q [1:31];

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 1; i < 32; i++) begin
                regs_q[i] <= '0;
            end
        end else if (we_i && rd_addr_i != '0) begin
            regs_q[rd_addr_i] <= rd_data_i;
        end
    end

    // old value on a same-cycle write, decode forwards the new one
    assign rs1_data_o = (rs1_addr_i == '0) ? '0 : regs_q[rs1_addr_i];
    assign rs2_data_o = (rs2_addr_i == '0) ? '0 : regs_q[rs2_addr_i];

endmodule

// File: run.sh
#!/usr/bin/env bash
# build and run the gs_core testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/100ps \
    --top-module tb_gs_core -f flist.f \
    --Mdir obj_dir -o vtb_gs_core
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

./obj_dir/vtb_gs_core
status=$?
if [ $status -ne 0 ]; then
    echo "simulation failed with status $status"
    exit 1
fi

echo "simulation finished cleanly"
exit 0

// File: tb_gs_core.sv
`timescale 1ns/100ps
module tb_gs_core;

    localparam int          CLK_HALF    = 50;
    localparam int          WD_MARGIN   = 40;
    localparam logic [31:0] MARKER_ADDR = 32'h0000_03f0;
    localparam int          POISON_ADDR = 'h200;
    localparam int          POISON      = 'h5a5;

    logic        clk;
    logic        rst_n;
    logic [31:0] im_addr, im_data, dm_addr, dm_wdata, dm_rdata;
    logic        dm_we;

    logic [31:0] rom  [0:63];
    logic [31:0] dmem [0:255];
    int          n_instr;
    int          wd_cycles;

    // expected stores in program order
    logic [31:0] exp_addr [$];
    logic [31:0] exp_data [$];
    string       exp_name [$];
    int          exp_idx;

    gs_core u_gs_core (
        .clk_i (clk), .rst_n_i (rst_n),
        .im_addr_o (im_addr), .im_data_i (im_data),
        .dm_addr_o (dm_addr), .dm_wdata_o (dm_wdata), .dm_we_o (dm_we),
        .dm_rdata_i (dm_rdata)
    );

    // rv32i encoders
    function automatic logic [31:0] enc_r(input logic [6:0] f7, input int rs2, input int rs1,
                                          input logic [2:0] f3, input int rd);
        return {f7, rs2[4:0], rs1[4:0], f3, rd[4:0], gs_pkg::OPC_OP};
    endfunction

    function automatic logic [31:0] enc_i(input int imm, input int rs1, input logic [2:0] f3,
                                          input int rd, input logic [6:0] opc);
        return {imm[11:0], rs1[4:0], f3, rd[4:0], opc};
    endfunction

    function automatic logic [31:0] enc_s(input int off, input int rs2, input int rs1);
        return {off[11:5], rs2[4:0], rs1[4:0], 3'b010, off[4:0], gs_pkg::OPC_STORE};
    endfunction

    function automatic logic [31:0] enc_b(input int off, input int rs2, input int rs1,
                                          input logic [2:0] f3);
        return {off[12], off[10:5], rs2[4:0], rs1[4:0], f3, off[4:1], off[11],
                gs_pkg::OPC_BRANCH};
    endfunction

    function automatic logic [31:0] enc_j(input int off, input int rd);
        return {off[20], off[10:1], off[11], off[19:12], rd[4:0], gs_pkg::OPC_JAL};
    endfunction

    // signed value that fits an 11-bit field
    function automatic int draw_imm();
        return int'($urandom_range(2047, 0)) - 1024;
    endfunction

    task automatic emit(input logic [31:0] word);
        rom[n_instr] = word;
        n_instr++;
    endtask

    task automatic expect_store(input logic [31:0] addr, input logic [31:0] data,
                                input string name);
        exp_addr.push_back(addr);
        exp_data.push_back(data);
        exp_name.push_back(name);
    endtask

    task automatic abort_run(input string why);
        $display("TEST FAILED");
        $fatal(1, "%s", why);
    endtask

    // the marker store ends the run and every other store takes the next entry
    task automatic check_store(input logic [31:0] addr, input logic [31:0] data);
        int cur;
        if (addr == MARKER_ADDR) begin
            if (exp_idx == exp_addr.size()) begin
                $display("TEST OK");
                $finish;
            end else begin
                abort_run($sformatf("marker store reached with %0d expected stores missing",
                                    exp_addr.size() - exp_idx));
            end
        end else if (exp_idx >= exp_addr.size()) begin
            abort_run($sformatf("extra store of %h to %h", data, addr));
        end else begin
            cur = exp_idx;
            exp_idx++;
            assert (addr == exp_addr[cur] && data == exp_data[cur]) else begin
                $display("Error %s: expected %h at %h, actual %h at %h", exp_name[cur],
                         exp_data[cur], exp_addr[cur], data, addr);
                abort_run("stopped at the first wrong store");
            end
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #CLK_HALF clk = ~clk;
    end

    // combinational instruction and data reads
    assign im_data  = rom[im_addr[7:2]];
    assign dm_rdata = dmem[dm_addr[9:2]];

    // fill tied to the full byte address
    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 256; i++) begin
                dmem[i] <= 32'hd0d0_0000 ^ (i * 4);
            end
        end else if (dm_we) begin
            dmem[dm_addr[9:2]] <= dm_wdata;
        end
    end

    // registered store outputs are stable at the falling edge
    always @(negedge clk) begin
        if (rst_n && dm_we) begin
            check_store(dm_addr, dm_wdata);
        end
    end

    initial begin
        wait (wd_cycles > 0);
        repeat (wd_cycles) @(posedge clk);
        abort_run("program did not finish before the watchdog limit");
    end

    initial begin
        int          imm_a, imm_b, imm_c, imm_d, imm_e, imm_f;
        int          jal_idx, jalr_idx;
        logic [31:0] r3, r4, r5, r6, r7, r11;
        void'($urandom(45));
        rst_n     = 1'b1;
        n_instr   = 0;
        exp_idx   = 0;
        wd_cycles = 0;
        for (int i = 0; i < 64; i++) begin
            rom[i] = '0;
        end
        imm_a = draw_imm();
        imm_b = draw_imm();
        imm_c = draw_imm();
        imm_d = draw_imm();
        imm_e = draw_imm();
        imm_f = draw_imm();
        // beq and bne need two different operands
        if (imm_b == imm_a) begin
            imm_b = imm_a ^ 1;
        end

        // alu chains where back to back hits execute and one apart hits writeback
        emit(enc_i(POISON, 0, gs_pkg::F3_ADD, 31, gs_pkg::OPC_OP_IMM));
        emit(enc_i(imm_a, 0, gs_pkg::F3_ADD, 1, gs_pkg::OPC_OP_IMM));
        emit(enc_i(imm_b, 0, gs_pkg::F3_ADD, 2, gs_pkg::OPC_OP_IMM));
        emit(enc_r(7'h00, 2, 1, gs_pkg::F3_ADD, 3));
        emit(enc_r(7'h20, 1, 3, gs_pkg::F3_ADD, 4));
        emit(enc_r(7'h00, 3, 4, gs_pkg::F3_XOR, 5));
        emit(enc_r(7'h00, 2, 5, gs_pkg::F3_AND, 6));
        emit(enc_r(7'h00, 4, 6, gs_pkg::F3_OR, 7));
        emit(enc_r(7'h00, 2, 1, gs_pkg::F3_SLT, 8));
        for (int r = 3; r <= 8; r++) begin
            emit(enc_s('h100 + (r - 3) * 4, r, 0));
        end
        emit(enc_i(imm_c, 7, gs_pkg::F3_XOR, 9, gs_pkg::OPC_OP_IMM));
        emit(enc_i(imm_d, 9, gs_pkg::F3_AND, 10, gs_pkg::OPC_OP_IMM));
        emit(enc_i(imm_e, 10, gs_pkg::F3_OR, 11, gs_pkg::OPC_OP_IMM));
        emit(enc_s('h118, 11, 0));
        // load then an immediate user costs one stall
        emit(enc_s('h120, 5, 0));
        emit(enc_i('h120, 0, 3'b010, 13, gs_pkg::OPC_LOAD));
        emit(enc_i(imm_f, 13, gs_pkg::F3_ADD, 14, gs_pkg::OPC_OP_IMM));
        emit(enc_s('h124, 14, 0));
        // branches with poison in every wrong-path slot
        emit(enc_b(12, 1, 1, gs_pkg::F3_BEQ));
        emit(enc_s(POISON_ADDR, 31, 0));
        emit(enc_s(POISON_ADDR, 31, 0));
        emit(enc_b(8, 2, 1, gs_pkg::F3_BEQ));
        emit(enc_s('h128, 1, 0));
        emit(enc_b(12, 2, 1, gs_pkg::F3_BNE));
        emit(enc_s(POISON_ADDR, 31, 0));
        emit(enc_s(POISON_ADDR, 31, 0));
        emit(enc_b(8, 1, 1, gs_pkg::F3_BNE));
        emit(enc_s('h12c, 2, 0));
        // jal over two poison slots
        jal_idx = n_instr;
        emit(enc_j(12, 16));
        emit(enc_s(POISON_ADDR, 31, 0));
        emit(enc_s(POISON_ADDR, 31, 0));
        emit(enc_s('h130, 16, 0));
        // odd jalr base so the target needs bit 0 cleared
        jalr_idx = n_instr + 1;
        emit(enc_i((jalr_idx + 3) * 4 - 3, 0, gs_pkg::F3_ADD, 17, gs_pkg::OPC_OP_IMM));
        emit(enc_i(4, 17, 3'b000, 18, gs_pkg::OPC_JALR));
        emit(enc_s(POISON_ADDR, 31, 0));
        emit(enc_s(POISON_ADDR, 31, 0));
        emit(enc_s('h134, 18, 0));
        // x0 ignores the write
        emit(enc_i('h123, 0, gs_pkg::F3_ADD, 0, gs_pkg::OPC_OP_IMM));
        emit(enc_s('h138, 0, 0));
        emit(enc_s(int'(MARKER_ADDR), 1, 0));
        emit(enc_j(0, 0));

        r3  = imm_a + imm_b;
        r4  = r3 - imm_a;
        r5  = r4 ^ r3;
        r6  = r5 & imm_b;
        r7  = r6 | r4;
        r11 = ((r7 ^ imm_c) & imm_d) | imm_e;
        expect_store(32'h100, r3, "add_fwd");
        expect_store(32'h104, r4, "sub_fwd");
        expect_store(32'h108, r5, "xor_fwd");
        expect_store(32'h10c, r6, "and_fwd");
        expect_store(32'h110, r7, "or_fwd");
        expect_store(32'h114, (imm_a < imm_b) ? 32'd1 : 32'd0, "slt_signed");
        expect_store(32'h118, r11, "imm_chain");
        expect_store(32'h120, r5, "store_before_load");
        expect_store(32'h124, r5 + imm_f, "load_use");
        expect_store(32'h128, imm_a, "beq_not_taken");
        expect_store(32'h12c, imm_b, "bne_not_taken");
        expect_store(32'h130, jal_idx * 4 + 4, "jal_link");
        expect_store(32'h134, jalr_idx * 4 + 4, "jalr_link");
        expect_store(32'h138, 32'd0, "x0_write");

        #1 rst_n = 1'b0;
        repeat (3) @(posedge clk);
        #1 rst_n = 1'b1;
        wd_cycles = n_instr * 4 + WD_MARGIN;
        assert (im_addr == gs_pkg::BOOT_ADDR && !dm_we) else begin
            $display("Error reset_state: expected pc %h we 0, actual pc %h we %b",
                     gs_pkg::BOOT_ADDR, im_addr, dm_we);
            abort_run("core left reset in the wrong state");
        end
    end

endmodule
